// ==== filelist.f ====
rtl/i2c_pkg.sv
rtl/i2c_bit_engine.sv
rtl/i2c_txn_ctrl.sv
rtl/i2c_stall_watch.sv
rtl/i2c_timeout_master.sv
sim/i2c_slave_model.sv
sim/tb_i2c_timeout_master.sv

// ==== rtl/i2c_bit_engine.sv ====
// I2C bit engine
`timescale 1ns/10ps
module i2c_bit_engine import i2c_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_valid,
    input  bit_cmd_t cmd,
    input  logic     cmd_bit,
    input  logic     scl_in,
    input  logic     sda_in,
    input  logic     bus_abort,
    output logic     cmd_ready,
    output logic     bit_done,
    output logic     rx_bit,
    output logic     scl_oe,
    output logic     sda_oe,
    output logic     scl_wait
);

    logic            active;
    bit_cmd_t        cmd_r;
    logic            bit_r;
    logic [1:0]      phase;
    logic [1:0]      next_phase;
    logic [QC_W-1:0] qcnt;
    logic            quarter_end;

    // SCL pull-down per command and phase
    function automatic logic scl_low(bit_cmd_t c, logic [1:0] ph);
        case (c)
            CMD_START: return ph == 2'd3;
            CMD_STOP:  return ph < 2'd2;
            default:   return ph == 2'd0 || ph == 2'd3;
        endcase
    endfunction

    // SDA pull-down per command and phase, START falls and STOP rises with SCL high
    function automatic logic sda_low(bit_cmd_t c, logic b, logic [1:0] ph);
        case (c)
            CMD_START: return ph != 2'd0;
            CMD_STOP:  return ph != 2'd3;
            CMD_WRITE: return !b;
            default:   return 1'b0;
        endcase
    endfunction

    assign cmd_ready   = !active;
    // Released SCL still held low by the slave
    assign scl_wait    = active && !scl_oe && !scl_in;
    assign quarter_end = active && !scl_wait && qcnt == QC_W'(QUARTER_CYCLES - 1);
    assign next_phase  = phase + 2'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            phase    <= 2'd0;
            qcnt     <= '0;
            bit_done <= 1'b0;
            rx_bit   <= 1'b0;
            scl_oe   <= 1'b0;
            sda_oe   <= 1'b0;
        end else if (bus_abort) begin
            // Drop the command and let go of both lines
            active   <= 1'b0;
            phase    <= 2'd0;
            qcnt     <= '0;
            bit_done <= 1'b0;
            scl_oe   <= 1'b0;
            sda_oe   <= 1'b0;
        end else begin
            bit_done <= 1'b0;
            if (cmd_valid && cmd_ready) begin
                active <= 1'b1;
                phase  <= 2'd0;
                qcnt   <= '0;
                scl_oe <= scl_low(cmd, 2'd0);
                sda_oe <= sda_low(cmd, cmd_bit, 2'd0);
            end else if (quarter_end) begin
                qcnt <= '0;
                // End of phase 1 is the middle of the SCL high time
                if (phase == 2'd1) begin
                    rx_bit <= sda_in;
                end
                if (phase == 2'd3) begin
                    active   <= 1'b0;
                    bit_done <= 1'b1;
                end else begin
                    phase  <= next_phase;
                    scl_oe <= scl_low(cmd_r, next_phase);
                    sda_oe <= sda_low(cmd_r, bit_r, next_phase);
                end
            end else if (active && !scl_wait) begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_r <= cmd;
            bit_r <= cmd_bit;
        end
    end

    // Data changes under a released SCL only for START and STOP
    property p_sda_steady_scl_high;
        @(posedge clk) disable iff (!rst_n)
            (!scl_oe && !$past(scl_oe) && sda_oe != $past(sda_oe) && !$past(bus_abort))
            |-> (cmd_r == CMD_START || cmd_r == CMD_STOP);
    endproperty
    a_sda_steady_scl_high: assert property (p_sda_steady_scl_high);

endmodule

// ==== rtl/i2c_pkg.sv ====
// I2C master shared definitions
package i2c_pkg;

    // Bus timing in clk cycles
    localparam int QUARTER_CYCLES = 4;
    localparam int QC_W           = $clog2(QUARTER_CYCLES);

    // Longest tolerated wait for SCL to read high
    localparam int STALL_LIMIT    = 200;
    localparam int STALL_W        = $clog2(STALL_LIMIT + 1);

    // Commands understood by the bit engine
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_t;

    // Transaction sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_ADDR,
        ST_ADDR_ACK,
        ST_DATA,
        ST_DATA_ACK,
        ST_STOP,
        ST_RESP
    } txn_state_t;

endpackage

// ==== rtl/i2c_stall_watch.sv ====
// SCL stall watchdog
`timescale 1ns/10ps
module i2c_stall_watch import i2c_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic scl_wait,
    output logic bus_abort
);

    logic [STALL_W-1:0] wait_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt  <= '0;
            bus_abort <= 1'b0;
        end else begin
            // Fires once per stall, the saturated count blocks a repeat
            bus_abort <= scl_wait && wait_cnt == STALL_W'(STALL_LIMIT - 1);
            if (!scl_wait) begin
                wait_cnt <= '0;
            end else if (wait_cnt != STALL_W'(STALL_LIMIT)) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    a_abort_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) bus_abort |=> !bus_abort);

endmodule

// ==== rtl/i2c_timeout_master.sv ====
// I2C master with stall timeout
`timescale 1ns/10ps
module i2c_timeout_master import i2c_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  logic [6:0] slave_addr,
    input  logic       rw,
    input  logic [7:0] write_data,
    input  logic       rsp_ready,
    output logic       req_ready,
    output logic       rsp_valid,
    output logic [7:0] read_data,
    output logic       nack,
    output logic       timeout_error,
    output logic       busy,
    inout  wire        scl,
    inout  wire        sda
);

    logic     cmd_valid;
    logic     cmd_ready;
    bit_cmd_t cmd;
    logic     cmd_bit;
    logic     bit_done;
    logic     rx_bit;
    logic     bus_abort;
    logic     scl_oe;
    logic     sda_oe;
    logic     scl_wait;

    // Open-drain pads
    assign scl = scl_oe ? 1'b0 : 1'bz;
    assign sda = sda_oe ? 1'b0 : 1'bz;

    i2c_txn_ctrl u_txn (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .slave_addr    (slave_addr),
        .rw            (rw),
        .write_data    (write_data),
        .rsp_ready     (rsp_ready),
        .cmd_ready     (cmd_ready),
        .bit_done      (bit_done),
        .rx_bit        (rx_bit),
        .bus_abort     (bus_abort),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .read_data     (read_data),
        .nack          (nack),
        .timeout_error (timeout_error),
        .busy          (busy),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_bit       (cmd_bit)
    );

    i2c_bit_engine u_bit (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_bit   (cmd_bit),
        .scl_in    (scl),
        .sda_in    (sda),
        .bus_abort (bus_abort),
        .cmd_ready (cmd_ready),
        .bit_done  (bit_done),
        .rx_bit    (rx_bit),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe),
        .scl_wait  (scl_wait)
    );

    i2c_stall_watch u_watch (
        .clk       (clk),
        .rst_n     (rst_n),
        .scl_wait  (scl_wait),
        .bus_abort (bus_abort)
    );

endmodule

// ==== rtl/i2c_txn_ctrl.sv ====
// I2C transaction sequencer
`timescale 1ns/10ps
module i2c_txn_ctrl import i2c_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  logic [6:0] slave_addr,
    input  logic       rw,
    input  logic [7:0] write_data,
    input  logic       rsp_ready,
    input  logic       cmd_ready,
    input  logic       bit_done,
    input  logic       rx_bit,
    input  logic       bus_abort,
    output logic       req_ready,
    output logic       rsp_valid,
    output logic [7:0] read_data,
    output logic       nack,
    output logic       timeout_error,
    output logic       busy,
    output logic       cmd_valid,
    output bit_cmd_t   cmd,
    output logic       cmd_bit
);

    txn_state_t state;
    logic       in_flight;
    logic [2:0] bit_cnt;
    logic [7:0] addr_shift;
    logic [7:0] data_r;
    logic       rw_r;

    assign req_ready = state == ST_IDLE;
    assign rsp_valid = state == ST_RESP;
    assign busy      = state != ST_IDLE;
    assign cmd_valid = !in_flight && state != ST_IDLE && state != ST_RESP;

    // Command for the current state
    always_comb begin
        cmd     = CMD_START;
        cmd_bit = 1'b1;
        case (state)
            ST_ADDR: begin
                cmd     = CMD_WRITE;
                cmd_bit = addr_shift[7];
            end
            ST_ADDR_ACK: cmd = CMD_READ;
            ST_DATA: begin
                cmd     = rw_r ? CMD_READ : CMD_WRITE;
                cmd_bit = data_r[7];
            end
            // Master NACKs the single read byte
            ST_DATA_ACK: cmd = rw_r ? CMD_WRITE : CMD_READ;
            ST_STOP:     cmd = CMD_STOP;
            default:     cmd = CMD_START;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            in_flight     <= 1'b0;
            bit_cnt       <= 3'd0;
            read_data     <= 8'd0;
            nack          <= 1'b0;
            timeout_error <= 1'b0;
        end else if (bus_abort && in_flight) begin
            // Stalled bus, engine has already released the lines
            state         <= ST_RESP;
            in_flight     <= 1'b0;
            timeout_error <= 1'b1;
        end else begin
            if (bit_done) begin
                in_flight <= 1'b0;
            end else if (cmd_valid && cmd_ready) begin
                in_flight <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state         <= ST_START;
                        bit_cnt       <= 3'd0;
                        read_data     <= 8'd0;
                        nack          <= 1'b0;
                        timeout_error <= 1'b0;
                    end
                end
                ST_START: begin
                    if (bit_done) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (bit_done) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_ADDR_ACK;
                        end
                    end
                end
                ST_ADDR_ACK: begin
                    if (bit_done) begin
                        if (rx_bit) begin
                            nack  <= 1'b1;
                            state <= ST_STOP;
                        end else begin
                            state <= ST_DATA;
                        end
                    end
                end
                ST_DATA: begin
                    if (bit_done) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_DATA_ACK;
                        end
                    end
                end
                ST_DATA_ACK: begin
                    if (bit_done) begin
                        if (rw_r) begin
                            read_data <= data_r;
                        end else begin
                            nack <= rx_bit;
                        end
                        state <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (bit_done) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Byte shifters, MSB first in both directions
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            addr_shift <= {slave_addr, rw};
            data_r     <= write_data;
            rw_r       <= rw;
        end else if (bit_done) begin
            if (state == ST_ADDR) begin
                addr_shift <= {addr_shift[6:0], 1'b0};
            end
            if (state == ST_DATA) begin
                data_r <= {data_r[6:0], rx_bit};
            end
        end
    end

    // New command only toward an idle engine
    a_cmd_to_idle_engine: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(cmd_valid) |-> cmd_ready);

    a_rsp_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
            rsp_valid && !rsp_ready |=> rsp_valid && $stable(read_data)
                && $stable(nack) && $stable(timeout_error));

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module tb_i2c_timeout_master -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -x "Test OK" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== sim/i2c_slave_model.sv ====
// Behavioral I2C slave
`timescale 1ns/10ps
module i2c_slave_model import i2c_pkg::*; #(
    parameter logic [6:0] ADDR = 7'h2A
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  tx_byte,
    input  logic [15:0] stretch_cycles,
    output logic [7:0]  rx_byte,
    inout  wire         scl,
    inout  wire         sda
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_WRITE,
        S_READ
    } slave_state_t;

    slave_state_t state;
    logic         scl_q;
    logic         sda_q;
    logic [3:0]   bit_cnt;
    logic [7:0]   shreg;
    logic [7:0]   tx_sh;
    logic [15:0]  stretch_cnt;
    logic [7:0]   hi_cnt;
    logic         sda_oe;
    logic         start_cond;
    logic         stop_cond;
    logic         scl_rise;
    logic         scl_fall;

    // Open-drain outputs, SCL held low while stretching
    assign scl = (stretch_cnt != 16'd0) ? 1'b0 : 1'bz;
    assign sda = sda_oe ? 1'b0 : 1'bz;

    assign start_cond = scl_q && scl && sda_q && !sda;
    assign stop_cond  = scl_q && scl && !sda_q && sda;
    assign scl_rise   = !scl_q && scl;
    assign scl_fall   = scl_q && !scl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            bit_cnt     <= 4'd0;
            shreg       <= 8'd0;
            tx_sh       <= 8'd0;
            stretch_cnt <= 16'd0;
            hi_cnt      <= 8'd0;
            sda_oe      <= 1'b0;
            rx_byte     <= 8'd0;
        end else begin
            scl_q  <= scl;
            sda_q  <= sda;
            hi_cnt <= (scl && state != S_IDLE) ? hi_cnt + 8'd1 : 8'd0;
            if (stretch_cnt != 16'd0) begin
                stretch_cnt <= stretch_cnt - 16'd1;
            end
            if (start_cond) begin
                // The SCL fall that ends START is not a data bit
                state   <= S_ADDR;
                bit_cnt <= 4'd15;
                sda_oe  <= 1'b0;
            end else if (stop_cond || hi_cnt == 8'(16 * QUARTER_CYCLES)) begin
                // STOP, or a transfer abandoned by the master
                state  <= S_IDLE;
                sda_oe <= 1'b0;
            end else begin
                if (scl_rise && bit_cnt < 4'd8) begin
                    shreg <= {shreg[6:0], sda};
                end
                if (scl_fall) begin
                    bit_cnt <= (bit_cnt == 4'd8) ? 4'd0 : bit_cnt + 4'd1;
                    case (state)
                        S_ADDR: begin
                            if (bit_cnt == 4'd7) begin
                                if (shreg[7:1] == ADDR) begin
                                    sda_oe <= 1'b1;
                                end else begin
                                    state <= S_IDLE;
                                end
                            end else if (bit_cnt == 4'd8) begin
                                // Low phase of the first data bit
                                stretch_cnt <= stretch_cycles;
                                if (shreg[0]) begin
                                    state  <= S_READ;
                                    sda_oe <= !tx_byte[7];
                                    tx_sh  <= {tx_byte[6:0], 1'b1};
                                end else begin
                                    state  <= S_WRITE;
                                    sda_oe <= 1'b0;
                                end
                            end
                        end
                        S_WRITE: begin
                            if (bit_cnt == 4'd7) begin
                                rx_byte <= shreg;
                                sda_oe  <= 1'b1;
                            end else if (bit_cnt == 4'd8) begin
                                sda_oe <= 1'b0;
                                state  <= S_IDLE;
                            end
                        end
                        S_READ: begin
                            if (bit_cnt < 4'd7) begin
                                sda_oe <= !tx_sh[7];
                                tx_sh  <= {tx_sh[6:0], 1'b1};
                            end else if (bit_cnt == 4'd7) begin
                                // Master drives its ACK or NACK
                                sda_oe <= 1'b0;
                            end else begin
                                state <= S_IDLE;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

// ==== sim/tb_i2c_timeout_master.sv ====
// I2C master testbench
`timescale 1ns/10ps
module tb_i2c_timeout_master import i2c_pkg::*; ();

    localparam logic [6:0] MODEL_ADDR     = 7'h2A;
    localparam int         STRETCH_MARGIN = 50;
    localparam int         NUM_DIRECTED   = 8;
    localparam int         NUM_RANDOM     = 40;
    localparam int         NUM_TXN        = NUM_DIRECTED + NUM_RANDOM;
    localparam int         CLK_PERIOD     = 40;
    // START, 18 bits and STOP, doubled for handshake gaps and bus recovery
    localparam int         WORST_TXN      = 2 * 20 * 4 * QUARTER_CYCLES;
    localparam longint     WATCHDOG_NS    =
        longint'(NUM_TXN) * (WORST_TXN + STALL_LIMIT) * CLK_PERIOD + 20000;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic [6:0]  slave_addr;
    logic        rw;
    logic [7:0]  write_data;
    logic        rsp_ready;
    logic        req_ready;
    logic        rsp_valid;
    logic [7:0]  read_data;
    logic        nack;
    logic        timeout_error;
    logic        busy;
    wire         scl;
    wire         sda;
    logic [7:0]  tx_byte;
    logic [15:0] stretch_cycles;
    logic [7:0]  rx_byte;

    logic [15:0] lfsr_state;
    // Expected response of the transaction in flight
    logic [7:0]  exp_read_data;
    logic        exp_nack;
    logic        exp_timeout;
    logic        exp_rw;
    logic [7:0]  exp_rx_byte;
    int          n_checked;
    int          err_count;

    pullup (scl);
    pullup (sda);

    i2c_timeout_master u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .slave_addr    (slave_addr),
        .rw            (rw),
        .write_data    (write_data),
        .rsp_ready     (rsp_ready),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .read_data     (read_data),
        .nack          (nack),
        .timeout_error (timeout_error),
        .busy          (busy),
        .scl           (scl),
        .sda           (sda)
    );

    i2c_slave_model #(.ADDR(MODEL_ADDR)) u_slave (
        .clk            (clk),
        .rst_n          (rst_n),
        .tx_byte        (tx_byte),
        .stretch_cycles (stretch_cycles),
        .rx_byte        (rx_byte),
        .scl            (scl),
        .sda            (sda)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = 16'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Expected {read_data, nack, timeout_error}
    function automatic logic [9:0] expect_response(input logic [6:0] addr, input logic rd,
                                                   input logic [7:0] tx,
                                                   input logic [15:0] stretch);
        if (addr != MODEL_ADDR) begin
            return {8'h00, 1'b1, 1'b0};
        end
        if (stretch >= 16'(STALL_LIMIT + STRETCH_MARGIN)) begin
            return {8'h00, 1'b0, 1'b1};
        end
        return {rd ? tx : 8'h00, 1'b0, 1'b0};
    endfunction

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic wait_bus_idle();
        while (scl !== 1'b1 || sda !== 1'b1) begin
            @(posedge clk);
        end
    endtask

    task automatic run_txn(input logic [6:0] addr, input logic rd, input logic [7:0] wdata,
                           input logic [7:0] tx, input logic [15:0] stretch, input int hold);
        logic [9:0] exp;
        logic [7:0] held_data;
        logic       held_nack;
        logic       held_timeout;
        @(posedge clk);
        exp           = expect_response(addr, rd, tx, stretch);
        exp_read_data = exp[9:2];
        exp_nack      = exp[1];
        exp_timeout   = exp[0];
        exp_rw        = rd;
        if (addr == MODEL_ADDR && !rd && !exp[0]) begin
            exp_rx_byte = wdata;
        end
        tx_byte        <= tx;
        stretch_cycles <= stretch;
        slave_addr     <= addr;
        rw             <= rd;
        write_data     <= wdata;
        req_valid      <= 1'b1;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
        do @(posedge clk); while (!rsp_valid);
        held_data    = read_data;
        held_nack    = nack;
        held_timeout = timeout_error;
        check_value("busy with response pending", 16'(busy), 16'd1);
        if (exp_timeout) begin
            // Aborted transfer leaves both pads released
            check_value("scl_oe after abort", 16'(u_dut.scl_oe), 16'd0);
            check_value("sda_oe after abort", 16'(u_dut.sda_oe), 16'd0);
        end
        repeat (hold) begin
            @(posedge clk);
            check_value("rsp_valid held", 16'(rsp_valid), 16'd1);
            check_value("read_data held", 16'(read_data), 16'(held_data));
            check_value("nack held", 16'(nack), 16'(held_nack));
            check_value("timeout_error held", 16'(timeout_error), 16'(held_timeout));
            check_value("req_ready while held", 16'(req_ready), 16'd0);
            check_value("busy while held", 16'(busy), 16'd1);
        end
        rsp_ready <= 1'b1;
        @(posedge clk);
        rsp_ready <= 1'b0;
        wait_bus_idle();
    endtask

    // Response checker
    always @(posedge clk) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            check_value("nack", 16'(nack), 16'(exp_nack));
            check_value("timeout_error", 16'(timeout_error), 16'(exp_timeout));
            if (exp_rw && !exp_nack && !exp_timeout) begin
                check_value("read_data", 16'(read_data), 16'(exp_read_data));
            end
            check_value("slave rx_byte", 16'(rx_byte), 16'(exp_rx_byte));
            n_checked++;
        end
    end

    initial begin
        logic [6:0]  addr;
        logic        rd;
        logic [7:0]  wdata;
        logic [7:0]  tx;
        logic [15:0] stretch;
        logic [2:0]  sel;
        int          hold;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        slave_addr     = 7'd0;
        rw             = 1'b0;
        write_data     = 8'd0;
        rsp_ready      = 1'b0;
        tx_byte        = 8'd0;
        stretch_cycles = 16'd0;
        lfsr_state     = 16'd11;
        exp_read_data  = 8'd0;
        exp_nack       = 1'b0;
        exp_timeout    = 1'b0;
        exp_rw         = 1'b0;
        exp_rx_byte    = 8'd0;
        n_checked      = 0;
        err_count      = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        run_txn(MODEL_ADDR, 1'b0, 8'hA5, 8'h00, 16'd0, 0);
        run_txn(MODEL_ADDR, 1'b1, 8'h00, 8'h3C, 16'd0, 0);
        run_txn(7'h15, 1'b0, 8'h5F, 8'h00, 16'd0, 0);
        run_txn(7'h2B, 1'b1, 8'h00, 8'h77, 16'd0, 0);
        run_txn(MODEL_ADDR, 1'b0, 8'h96, 8'h00, 16'd60, 0);
        // Stuck SCL, then a clean transfer
        run_txn(MODEL_ADDR, 1'b1, 8'h00, 8'h5A, 16'd320, 0);
        run_txn(MODEL_ADDR, 1'b0, 8'hC3, 8'h00, 16'd0, 0);
        run_txn(MODEL_ADDR, 1'b1, 8'h00, 8'hE1, 16'd0, 12);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            if (take_bits(2) == 16'd0) begin
                addr = 7'(take_bits(7));
                if (addr == MODEL_ADDR) begin
                    addr = addr ^ 7'h01;
                end
            end else begin
                addr = MODEL_ADDR;
            end
            rd    = 1'(take_bits(1));
            wdata = 8'(take_bits(8));
            tx    = 8'(take_bits(8));
            sel   = 3'(take_bits(3));
            // Stretches stay far from the stall limit
            case (sel)
                3'd0:      stretch = 16'd300 + take_bits(6);
                3'd1, 3'd2: stretch = 16'd1 + take_bits(6);
                default:   stretch = 16'd0;
            endcase
            hold = int'(take_bits(4));
            run_txn(addr, rd, wdata, tx, stretch, hold);
        end

        repeat (2) @(posedge clk);
        check_value("responses checked", 16'(n_checked), 16'(NUM_TXN));
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all transactions finished");
        $display("Test FAILED");
        $fatal(1, "simulation time limit reached");
    end

endmodule
